//--- Makefile
# Verilator build and run of the ising core testbench

VERILATOR ?= verilator
TOP       ?= ising_core_tb
FILELIST  ?= ising_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

SOURCES := $(wildcard design/*.sv tests/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/host_decoder.sv
/* host strobe routing to the J bank, the flip bank and the register file */

`timescale 1ns/10ps

`include "ising_cfg.svh"

module host_decoder (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  ising_pkg::host_req_t           host_req_i,
    output ising_pkg::host_rsp_t           host_rsp_o,
    input  logic                           busy_i,
    output logic                           j_we_o,
    output logic                           flip_we_o,
    output logic [`ISING_ROW_W-1:0]        wrow_o,
    output logic [`ISING_HOST_DATA_W-1:0]  wdata_o,
    output logic                           reg_we_o,
    output logic                           reg_re_o,
    output logic [`ISING_ROW_W-1:0]        reg_idx_o,
    output logic [`ISING_HOST_DATA_W-1:0]  reg_wdata_o,
    input  logic [`ISING_HOST_DATA_W-1:0]  reg_rdata_i
);

    ising_pkg::host_addr_u  addr_u;
    logic                   wr_stb, rd_stb;
    logic                   rvalid_q;

    assign addr_u = host_req_i.addr;
    assign wr_stb = host_req_i.strobe && host_req_i.write;
    assign rd_stb = host_req_i.strobe && !host_req_i.write;

    ////////////////////////////////////////
    // bank writes, held off during a run
    assign j_we_o    = wr_stb && addr_u.bank.region == `ISING_REGION_J && !busy_i;
    assign flip_we_o = wr_stb && addr_u.bank.region == `ISING_REGION_FLIP && !busy_i;
    assign wrow_o    = addr_u.bank.row;
    assign wdata_o   = host_req_i.wdata;

    ////////////////////////////////////////
    // register accesses
    assign reg_we_o    = wr_stb && addr_u.regs.region == `ISING_REGION_REG;
    assign reg_re_o    = rd_stb && addr_u.regs.region == `ISING_REGION_REG;
    assign reg_idx_o   = addr_u.regs.idx;
    assign reg_wdata_o = host_req_i.wdata;

    // every read is answered, reads outside the register region see zero data
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_stb;
        end
    end

    assign host_rsp_o.rvalid = rvalid_q;
    assign host_rsp_o.rdata  = reg_rdata_i;  // zero unless a register was read

    a_no_bank_write_busy: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) busy_i |-> !(j_we_o || flip_we_o)
    );

endmodule

//--- design/ising_core.sv
/* ising core top level: host decoder, registers, J and flip banks, spin engine */

`timescale 1ns/10ps

`include "ising_cfg.svh"

module ising_core (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  ising_pkg::host_req_t host_req_i,
    output ising_pkg::host_rsp_t host_rsp_o
);

    // host side
    logic                           j_we, flip_we;
    logic [`ISING_ROW_W-1:0]        wrow;
    logic [`ISING_HOST_DATA_W-1:0]  wdata;
    logic                           reg_we, reg_re;
    logic [`ISING_ROW_W-1:0]        reg_idx;
    logic [`ISING_HOST_DATA_W-1:0]  reg_wdata, reg_rdata;

    // engine side
    ising_pkg::engine_cfg_t         cfg;
    logic                           start, busy, done;
    logic [`ISING_NUM_SPIN-1:0]     spin;
    logic                           j_re, flip_re;
    logic [`ISING_ROW_W-1:0]        j_raddr, flip_raddr;
    logic [`ISING_J_ROW_W-1:0]      j_rdata;
    logic [`ISING_NUM_SPIN-1:0]     flip_rdata;

    host_decoder host_decoder_inst (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .host_req_i   (host_req_i ),
        .host_rsp_o   (host_rsp_o ),
        .busy_i       (busy       ),
        .j_we_o       (j_we       ),
        .flip_we_o    (flip_we    ),
        .wrow_o       (wrow       ),
        .wdata_o      (wdata      ),
        .reg_we_o     (reg_we     ),
        .reg_re_o     (reg_re     ),
        .reg_idx_o    (reg_idx    ),
        .reg_wdata_o  (reg_wdata  ),
        .reg_rdata_i  (reg_rdata  )
    );

    ising_regs ising_regs_inst (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .reg_we_i     (reg_we     ),
        .reg_re_i     (reg_re     ),
        .reg_idx_i    (reg_idx    ),
        .reg_wdata_i  (reg_wdata  ),
        .reg_rdata_o  (reg_rdata  ),
        .cfg_o        (cfg        ),
        .start_o      (start      ),
        .busy_i       (busy       ),
        .done_i       (done       ),
        .spin_i       (spin       )
    );

    ////////////////////////////////////////
    // L1 banks
    l1_bank #(
        .DEPTH (`ISING_J_DEPTH ),
        .WIDTH (`ISING_J_ROW_W )
    ) j_bank_inst (
        .clk_i    (clk_i    ),
        .we_i     (j_we     ),
        .waddr_i  (wrow     ),
        .wdata_i  (wdata    ),
        .re_i     (j_re     ),
        .raddr_i  (j_raddr  ),
        .rdata_o  (j_rdata  )
    );

    l1_bank #(
        .DEPTH (`ISING_FLIP_DEPTH ),
        .WIDTH (`ISING_NUM_SPIN   )
    ) flip_bank_inst (
        .clk_i    (clk_i                         ),
        .we_i     (flip_we                       ),
        .waddr_i  (wrow                          ),
        .wdata_i  (wdata[`ISING_NUM_SPIN-1:0]    ), // one mask per word
        .re_i     (flip_re                       ),
        .raddr_i  (flip_raddr                    ),
        .rdata_o  (flip_rdata                    )
    );

    spin_engine spin_engine_inst (
        .clk_i         (clk_i      ),
        .rst_n_i       (rst_n_i    ),
        .cfg_i         (cfg        ),
        .start_i       (start      ),
        .busy_o        (busy       ),
        .done_o        (done       ),
        .spin_o        (spin       ),
        .j_re_o        (j_re       ),
        .j_raddr_o     (j_raddr    ),
        .j_rdata_i     (j_rdata    ),
        .flip_re_o     (flip_re    ),
        .flip_raddr_o  (flip_raddr ),
        .flip_rdata_i  (flip_rdata )
    );

endmodule

//--- design/ising_pkg.sv
/* host bus structs, host address union and engine configuration struct */

`include "ising_cfg.svh"

package ising_pkg;

    ////////////////////////////////////////
    // host bus
    typedef struct packed {
        logic                           strobe;  // single-cycle request
        logic                           write;
        logic [`ISING_HOST_ADDR_W-1:0]  addr;
        logic [`ISING_HOST_DATA_W-1:0]  wdata;
    } host_req_t;

    typedef struct packed {
        logic                           rvalid;  // one cycle after a read strobe
        logic [`ISING_HOST_DATA_W-1:0]  rdata;
    } host_rsp_t;

    // address as seen by a memory bank
    typedef struct packed {
        logic [`ISING_REGION_W-1:0]     region;
        logic [`ISING_ROW_W-1:0]        row;
    } bank_addr_t;

    // address as seen by the register file
    typedef struct packed {
        logic [`ISING_REGION_W-1:0]     region;
        logic [`ISING_ROW_W-1:0]        idx;
    } reg_addr_t;

    typedef union packed {
        bank_addr_t                     bank;
        reg_addr_t                      regs;
    } host_addr_u;

    ////////////////////////////////////////
    // engine configuration
    typedef struct packed {
        logic [`ISING_STEP_W-1:0]       steps;
        logic [`ISING_FLIP_LAST_W-1:0]  flip_last;  // 0 disables flips
        logic [`ISING_HBIAS_W-1:0]      hbias;
        logic [`ISING_NUM_SPIN-1:0]     spin_init;
    } engine_cfg_t;

endpackage

//--- design/ising_regs.sv
/* configuration and status registers, start strobe and sticky done */

`timescale 1ns/10ps

`include "ising_cfg.svh"

module ising_regs (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           reg_we_i,
    input  logic                           reg_re_i,
    input  logic [`ISING_ROW_W-1:0]        reg_idx_i,
    input  logic [`ISING_HOST_DATA_W-1:0]  reg_wdata_i,
    output logic [`ISING_HOST_DATA_W-1:0]  reg_rdata_o,
    output ising_pkg::engine_cfg_t         cfg_o,
    output logic                           start_o,
    input  logic                           busy_i,
    input  logic                           done_i,
    input  logic [`ISING_NUM_SPIN-1:0]     spin_i
);

    ising_pkg::engine_cfg_t          cfg_q;
    logic                            done_q;  // sticky until the next start
    logic [`ISING_HOST_DATA_W-1:0]   rdata_d, rdata_q;

    // start is combinational so busy rises the cycle after the CTRL write
    assign start_o = reg_we_i && reg_idx_i == `ISING_REG_CTRL && reg_wdata_i[0] && !busy_i;

    ////////////////////////////////////////
    // config writes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q <= '0;
        end else if (reg_we_i) begin
            case (reg_idx_i)
                `ISING_REG_STEPS:     cfg_q.steps     <= reg_wdata_i[`ISING_STEP_W-1:0];
                `ISING_REG_SPIN:      cfg_q.spin_init <= reg_wdata_i[`ISING_NUM_SPIN-1:0];
                `ISING_REG_HBIAS:     cfg_q.hbias     <= reg_wdata_i;
                `ISING_REG_FLIP_LAST: cfg_q.flip_last <= reg_wdata_i[`ISING_FLIP_LAST_W-1:0];
                default: ;
            endcase
        end
    end

    assign cfg_o = cfg_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (start_o) begin
            done_q <= 1'b0;
        end else if (done_i) begin
            done_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // read path, one cycle latency
    always_comb begin
        rdata_d = '0;
        case (reg_idx_i)
            `ISING_REG_STEPS:     rdata_d[`ISING_STEP_W-1:0]      = cfg_q.steps;
            `ISING_REG_SPIN:      rdata_d[`ISING_NUM_SPIN-1:0]    = spin_i;  // live spins
            `ISING_REG_HBIAS:     rdata_d                         = cfg_q.hbias;
            `ISING_REG_FLIP_LAST: rdata_d[`ISING_FLIP_LAST_W-1:0] = cfg_q.flip_last;
            `ISING_REG_STATUS:    rdata_d[1:0]                    = {done_q, busy_i};
            default:              rdata_d                         = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= reg_re_i ? rdata_d : '0;  // idle cycles read as zero
        end
    end

    assign reg_rdata_o = rdata_q;

    // the engine must accept every start on the following edge
    a_start_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) start_o |-> !busy_i ##1 busy_i
    );

endmodule

//--- design/l1_bank.sv
/* single-port-write single-port-read synchronous memory bank */

`timescale 1ns/10ps

module l1_bank #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input  logic              clk_i,
    input  logic              we_i,
    input  logic [5:0]        waddr_i,
    input  logic [WIDTH-1:0]  wdata_i,
    input  logic              re_i,
    input  logic [5:0]        raddr_i,
    output logic [WIDTH-1:0]  rdata_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i[AW-1:0]] <= wdata_i;
        end
        if (re_i) begin
            rdata_q <= mem[raddr_i[AW-1:0]];  // valid the cycle after re_i
        end
    end

    assign rdata_o = rdata_q;

    a_waddr_range: assert property (@(posedge clk_i) we_i |-> waddr_i < DEPTH);
    a_raddr_range: assert property (@(posedge clk_i) re_i |-> raddr_i < DEPTH);

endmodule

//--- design/spin_engine.sv
/* annealing sequencer: per step a flip-mask XOR, then sequential sign updates
   of every spin from its local field */

`timescale 1ns/10ps

`include "ising_cfg.svh"

module spin_engine (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ising_pkg::engine_cfg_t      cfg_i,
    input  logic                        start_i,
    output logic                        busy_o,
    output logic                        done_o,
    output logic [`ISING_NUM_SPIN-1:0]  spin_o,
    output logic                        j_re_o,
    output logic [`ISING_ROW_W-1:0]     j_raddr_o,
    input  logic [`ISING_J_ROW_W-1:0]   j_rdata_i,
    output logic                        flip_re_o,
    output logic [`ISING_ROW_W-1:0]     flip_raddr_o,
    input  logic [`ISING_NUM_SPIN-1:0]  flip_rdata_i
);

    localparam int N   = `ISING_NUM_SPIN;
    localparam int BJ  = `ISING_BIT_J;
    localparam int BH  = `ISING_BIT_H;
    localparam int FW  = `ISING_FIELD_W;
    localparam int RW  = `ISING_ROW_W;
    localparam int FLW = `ISING_FLIP_LAST_W;
    localparam int SIW = $clog2(N);

    typedef enum logic [2:0] {S_IDLE, S_FLIP, S_ROW, S_UPD, S_DONE} state_e;

    state_e                    state_q;
    logic [`ISING_STEP_W-1:0]  step_q;
    logic [SIW-1:0]            idx_q;       // spin under update
    logic [FLW-1:0]            fptr_q;      // step index mod flip_last
    logic                      flip_pend_q; // flip word arrives in S_ROW
    logic [N-1:0]              spin_q;
    logic                      flip_on;
    logic signed [FW-1:0]      field;
    logic                      upd_bit;

    assign flip_on = cfg_i.flip_last != '0;

    assign busy_o       = state_q != S_IDLE;
    assign done_o       = state_q == S_DONE;  // last busy cycle
    assign spin_o       = spin_q;
    assign flip_re_o    = state_q == S_FLIP && flip_on;
    assign flip_raddr_o = RW'(fptr_q);
    assign j_re_o       = state_q == S_ROW;
    assign j_raddr_o    = RW'(idx_q);

    ////////////////////////////////////////
    // local field of spin idx_q, row data valid in S_UPD
    always_comb begin
        logic signed [BH-1:0] h_i;
        logic signed [BJ-1:0] j_ij;
        h_i   = cfg_i.hbias[idx_q*BH +: BH];
        field = {{(FW-BH){h_i[BH-1]}}, h_i};
        for (int j = 0; j < N; j++) begin
            j_ij = j_rdata_i[j*BJ +: BJ];
            if (j != int'(idx_q)) begin
                if (spin_q[j]) begin
                    field = field + {{(FW-BJ){j_ij[BJ-1]}}, j_ij};
                end else begin
                    field = field - {{(FW-BJ){j_ij[BJ-1]}}, j_ij};
                end
            end
        end
        // zero field keeps the old value
        if (field > 0) begin
            upd_bit = 1'b1;
        end else if (field < 0) begin
            upd_bit = 1'b0;
        end else begin
            upd_bit = spin_q[idx_q];
        end
    end

    ////////////////////////////////////////
    // sequencer
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            step_q      <= '0;
            idx_q       <= '0;
            fptr_q      <= '0;
            flip_pend_q <= 1'b0;
            spin_q      <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        spin_q  <= cfg_i.spin_init;
                        step_q  <= '0;
                        fptr_q  <= '0;
                        state_q <= (cfg_i.steps == '0) ? S_DONE : S_FLIP;
                    end
                end
                S_FLIP: begin
                    flip_pend_q <= flip_on;
                    if (flip_on) begin
                        fptr_q <= (fptr_q + 1'b1 == cfg_i.flip_last) ? '0 : fptr_q + 1'b1;
                    end
                    idx_q   <= '0;
                    state_q <= S_ROW;
                end
                S_ROW: begin
                    if (flip_pend_q) begin
                        spin_q <= spin_q ^ flip_rdata_i;  // before spin 0 is updated
                    end
                    flip_pend_q <= 1'b0;
                    state_q     <= S_UPD;
                end
                S_UPD: begin
                    spin_q[idx_q] <= upd_bit;
                    if (idx_q == SIW'(N - 1)) begin
                        step_q  <= step_q + 1'b1;
                        state_q <= (step_q + 1'b1 == cfg_i.steps) ? S_DONE : S_FLIP;
                    end else begin
                        idx_q   <= idx_q + 1'b1;
                        state_q <= S_ROW;
                    end
                end
                S_DONE:  state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    a_done_ends_run: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) done_o |-> busy_o ##1 !busy_o
    );

endmodule

//--- include/ising_cfg.svh
/* sizes, bus widths, address regions and register indices of the ising core */

`ifndef ISING_CFG_SVH
`define ISING_CFG_SVH

// spin array and arithmetic widths
`define ISING_NUM_SPIN       8
`define ISING_BIT_J          4    // signed coupling
`define ISING_BIT_H          4    // signed bias
`define ISING_FIELD_W        8    // signed local field
`define ISING_STEP_W         8
`define ISING_FLIP_LAST_W    5
`define ISING_J_ROW_W        32   // one row of J, 4 bits per entry
`define ISING_HBIAS_W        32   // all biases packed

// bank depths
`define ISING_J_DEPTH        8
`define ISING_FLIP_DEPTH     16

// host bus
`define ISING_HOST_DATA_W    32
`define ISING_HOST_ADDR_W    8
`define ISING_REGION_W       2
`define ISING_ROW_W          6

////////////////////////////////////////
// address map
`define ISING_REGION_REG     2'd0
`define ISING_REGION_J       2'd1
`define ISING_REGION_FLIP    2'd2

`define ISING_REG_CTRL       6'd0
`define ISING_REG_STEPS      6'd1
`define ISING_REG_SPIN       6'd2
`define ISING_REG_HBIAS      6'd3
`define ISING_REG_FLIP_LAST  6'd4
`define ISING_REG_STATUS     6'd5

`endif

//--- ising_core.f
+incdir+include
design/ising_pkg.sv
design/l1_bank.sv
design/host_decoder.sv
design/ising_regs.sv
design/spin_engine.sv
design/ising_core.sv
tests/tb_clock_gen.sv
tests/ising_core_tb.sv

//--- tests/ising_core_tb.sv
/* host bus tasks, reference spin model, compare process and watchdog
   for the ising core */

`timescale 1ns/10ps

`include "ising_cfg.svh"

module ising_core_tb;

    localparam int N          = `ISING_NUM_SPIN;
    localparam int BJ         = `ISING_BIT_J;
    localparam int BH         = `ISING_BIT_H;
    localparam int MAX_STEPS  = 6;
    localparam int NUM_RUNS   = 12;
    localparam int PERIOD_NS  = 10;
    localparam int RUN_CYCLES = MAX_STEPS * (1 + 2 * N) + 50;  // longest run plus loads and polls

    typedef struct packed {
        logic                           care;  // status polls are not compared
        logic [`ISING_HOST_ADDR_W-1:0]  addr;
        logic [`ISING_HOST_DATA_W-1:0]  data;
    } rd_exp_t;

    logic                       clk;
    logic                       rst_n;
    ising_pkg::host_req_t       host_req;
    ising_pkg::host_rsp_t       host_rsp;
    rd_exp_t                    rd_exp_q [$];  // reads in issue order
    int                         seed;

    // image of what the host has programmed
    logic [`ISING_J_ROW_W-1:0]  j_mem [N];
    logic [N-1:0]               flip_mem [`ISING_FLIP_DEPTH];
    logic [`ISING_HBIAS_W-1:0]  hbias;
    logic [N-1:0]               spin_init;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(8)) tb_clock_gen_inst (
        .clk_o   (clk  ),
        .rst_n_o (rst_n)
    );

    ising_core ising_core_inst (
        .clk_i      (clk     ),
        .rst_n_i    (rst_n   ),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp)
    );

    ////////////////////////////////////////
    // reference model
    function automatic logic [N-1:0] ref_spins(input logic [N-1:0] init, input int steps,
                                               input int flip_last);
        logic [N-1:0] s;
        int           field;
        s = init;
        for (int k = 0; k < steps; k++) begin
            if (flip_last != 0) begin
                s = s ^ flip_mem[k % flip_last];  // flip comes before the sweep
            end
            for (int i = 0; i < N; i++) begin
                field = int'($signed(hbias[BH*i +: BH]));
                for (int j = 0; j < N; j++) begin
                    if (j != i && s[j]) begin
                        field = field + int'($signed(j_mem[i][BJ*j +: BJ]));
                    end else if (j != i) begin
                        field = field - int'($signed(j_mem[i][BJ*j +: BJ]));
                    end
                end
                if (field > 0) begin
                    s[i] = 1'b1;
                end else if (field < 0) begin
                    s[i] = 1'b0;
                end
            end
        end
        return s;
    endfunction

    function automatic logic [7:0] reg_addr(input logic [5:0] idx);
        return {`ISING_REGION_REG, idx};
    endfunction

    function automatic logic [7:0] j_addr(input int row);
        return {`ISING_REGION_J, 6'(row)};
    endfunction

    function automatic logic [7:0] flip_addr(input int row);
        return {`ISING_REGION_FLIP, 6'(row)};
    endfunction

    task automatic error_stop(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    ////////////////////////////////////////
    // host bus tasks start 1 ns after a rising edge
    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        host_req.strobe = 1'b1;
        host_req.write  = 1'b1;
        host_req.addr   = addr;
        host_req.wdata  = data;
        @(posedge clk);
        #1 host_req = '0;
    endtask

    task automatic host_read(input logic [7:0] addr, input logic care, input logic [31:0] exp,
                             output logic [31:0] data);
        rd_exp_q.push_back('{care: care, addr: addr, data: exp});
        host_req.strobe = 1'b1;
        host_req.write  = 1'b0;
        host_req.addr   = addr;
        host_req.wdata  = '0;
        @(posedge clk);
        #1 host_req = '0;
        @(negedge clk);
        assert (host_rsp.rvalid)
            else error_stop($sformatf("no read response one cycle after the strobe at %0t", $time));
        data = host_rsp.rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [5:0] idx, input logic [31:0] data);
        host_write(reg_addr(idx), data);
    endtask

    task automatic read_check(input logic [5:0] idx, input logic [31:0] exp);
        logic [31:0] data;
        host_read(reg_addr(idx), 1'b1, exp, data);
    endtask

    task automatic read_reg(input logic [5:0] idx, output logic [31:0] data);
        host_read(reg_addr(idx), 1'b0, '0, data);
    endtask

    // random J, bias, initial spins and, if enabled, flip masks
    task automatic load_problem(input int flip_last);
        logic [31:0] word;
        for (int i = 0; i < N; i++) begin
            j_mem[i] = $random(seed);
            host_write(j_addr(i), j_mem[i]);
        end
        for (int f = 0; f < `ISING_FLIP_DEPTH && flip_last != 0; f++) begin
            word        = $random(seed);
            flip_mem[f] = word[N-1:0];  // upper bits are not stored
            host_write(flip_addr(f), word);
        end
        hbias     = $random(seed);
        word      = $random(seed);
        spin_init = word[N-1:0];
        write_reg(`ISING_REG_HBIAS, hbias);
        write_reg(`ISING_REG_SPIN, 32'(spin_init));
        write_reg(`ISING_REG_FLIP_LAST, 32'(flip_last));
    endtask

    task automatic start_run(input int steps);
        write_reg(`ISING_REG_STEPS, 32'(steps));
        write_reg(`ISING_REG_CTRL, 32'h1);
    endtask

    task automatic wait_done(output int polls);
        logic [31:0] status;
        polls = 0;
        do begin
            read_reg(`ISING_REG_STATUS, status);
            polls++;
        end while (!status[1]);
        assert (status == 32'h2)
            else error_stop($sformatf("Fail %0t: STATUS 0x%08h at end of run", $time, status));
    endtask

    task automatic run_and_check(input int steps, input int flip_last);
        logic [N-1:0] exp;
        int           polls;
        exp = ref_spins(spin_init, steps, flip_last);
        start_run(steps);
        wait_done(polls);
        read_check(`ISING_REG_SPIN, 32'(exp));
    endtask

    ////////////////////////////////////////
    // compare process
    always @(negedge clk) begin
        rd_exp_t e;
        if (rst_n && host_rsp.rvalid) begin
            assert (rd_exp_q.size() > 0)
                else error_stop($sformatf("read response at %0t without a read request", $time));
            e = rd_exp_q.pop_front();
            if (e.care) begin
                assert (host_rsp.rdata == e.data)
                    else error_stop($sformatf("Fail %0t: read of 0x%02h gave 0x%08h, expected 0x%08h",
                                              $time, e.addr, host_rsp.rdata, e.data));
            end
        end
    end

    // watchdog
    initial begin
        #(NUM_RUNS * RUN_CYCLES * PERIOD_NS);
        $display("watchdog expired: tests still running after %0d cycles", NUM_RUNS * RUN_CYCLES);
        $display("Done: errors found");
        $fatal(1, "stopped by the watchdog");
    end

    ////////////////////////////////////////
    // stimulus
    initial begin
        logic [N-1:0]               exp;
        logic [`ISING_J_ROW_W-1:0]  j_new [N];
        int                         steps;
        int                         flip_last;
        int                         polls;
        host_req = '0;
        seed     = 32'hcf7e;
        @(posedge rst_n);
        @(posedge clk);
        #1;

        // reset values
        read_check(`ISING_REG_STATUS, 32'h0);
        read_check(`ISING_REG_SPIN, 32'h0);
        read_check(`ISING_REG_STEPS, 32'h0);

        // register readback masked to field widths
        write_reg(`ISING_REG_STEPS, 32'hffff_ff5a);
        read_check(`ISING_REG_STEPS, 32'h0000_005a);
        write_reg(`ISING_REG_HBIAS, 32'hdead_beef);
        read_check(`ISING_REG_HBIAS, 32'hdead_beef);
        write_reg(`ISING_REG_FLIP_LAST, 32'hffff_ffe9);
        read_check(`ISING_REG_FLIP_LAST, 32'h0000_0009);
        read_check(6'd6, 32'h0);
        read_check(6'd63, 32'h0);

        repeat (4) begin  // no flips
            steps = 1 + int'($unsigned($random(seed)) % MAX_STEPS);
            load_problem(0);
            run_and_check(steps, 0);
        end

        repeat (4) begin  // with flip masks
            steps     = 1 + int'($unsigned($random(seed)) % MAX_STEPS);
            flip_last = 1 + int'($unsigned($random(seed)) % `ISING_FLIP_DEPTH);
            load_problem(flip_last);
            run_and_check(steps, flip_last);
        end

        // J writes during a run must not land
        load_problem(0);
        for (int i = 0; i < N; i++) begin
            j_new[i] = $random(seed);
        end
        exp = ref_spins(spin_init, MAX_STEPS, 0);
        start_run(MAX_STEPS);
        read_check(`ISING_REG_STATUS, 32'h1);  // busy with the old done cleared
        for (int i = 0; i < N; i++) begin
            host_write(j_addr(i), j_new[i]);
        end
        wait_done(polls);
        read_check(`ISING_REG_SPIN, 32'(exp));
        run_and_check(MAX_STEPS, 0);  // bank still holds the old J
        for (int i = 0; i < N; i++) begin
            j_mem[i] = j_new[i];
            host_write(j_addr(i), j_mem[i]);
        end
        run_and_check(MAX_STEPS, 0);

        // zero steps
        load_problem(0);
        start_run(0);
        wait_done(polls);
        assert (polls <= 2)
            else error_stop($sformatf("zero-step run took %0d status polls to finish", polls));
        read_check(`ISING_REG_SPIN, 32'(spin_init));

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
/* testbench clock and reset generator */

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released just after a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule
